// ==== verilog.f ====
src/ks10MemPkg.sv
src/memStatus.sv
src/ssramSeq.sv
src/memBusSlave.sv
src/ks10Mem.sv
tests/ssramModel.sv
tests/ks10MemTb.sv

// ==== Makefile ====
# Verilator build and run of the KS-10 memory interface testbench

SIM  = obj_dir/Vks10MemTb
SRCS = $(shell cat verilog.f)

.PHONY: all run clean

all: run

$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module ks10MemTb -Mdir obj_dir -f verilog.f

# The log decides pass or fail
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qxF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/ks10MemTb.sv ====
/*
 * Random transaction testbench for the KS-10 memory interface.
 * The LCG seed is fixed, so every run replays the same traffic.
 * Memory requests stay in a 256-word window so reads revisit writes.
 * Inputs change on the falling edge, outputs are sampled there too.
 */

module ks10MemTb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int addrW = 20;
   localparam logic [19:0] windowBase = 20'hB7300;
   // Cycles allowed for busAck
   localparam int ackLimit = 8;

   // Requests per test
   localparam int nMem = 200;
   localparam int nMsr = 60;
   localparam int nAc  = 20;
   localparam int nUna = 20;
   localparam int nMix = 100;
   // AC writes take two requests
   localparam int numTrans   = 1 + nMem + nMsr + 2 * nAc + nUna + 2 * nMix;
   localparam int cycleLimit = numTrans * 12 + 100;

   logic                clk;
   logic                rst;
   logic                busReq;
   logic                busAck;
   ks10MemPkg::word36_t busAddr;
   ks10MemPkg::word36_t busWrData;
   ks10MemPkg::word36_t busRdData;
   logic [addrW-1:0]    ssramAddr;
   logic                ssramCe;
   logic                ssramOeN;
   logic                ssramWeN;
   logic                ssramDataEn;
   ks10MemPkg::word36_t ssramWrData;
   ks10MemPkg::word36_t ssramRdData;

   // Reference model
   logic [35:0] modelMem [0:255];
   logic        modelPe;
   logic        modelEe;
   logic        modelPf;

   logic [31:0] rngState = 32'd38119;
   int          cycleCount = 0;
   int          testChecks = 0;
   int          testFails = 0;
   int          totalChecks = 0;
   int          totalFails = 0;

   ks10Mem #(.addrWidth(addrW)) DUT
   (
      .clk(clk), .rst(rst), .busReq(busReq), .busAck(busAck), .busAddr(busAddr),
      .busWrData(busWrData), .busRdData(busRdData), .ssramAddr(ssramAddr),
      .ssramCe(ssramCe), .ssramOeN(ssramOeN), .ssramWeN(ssramWeN),
      .ssramWrData(ssramWrData), .ssramDataEn(ssramDataEn), .ssramRdData(ssramRdData)
   );

   ssramModel #(.addrWidth(addrW)) sram
   (
      .clk(clk), .ssramAddr(ssramAddr), .ssramCe(ssramCe), .ssramOeN(ssramOeN),
      .ssramWeN(ssramWeN), .ssramWrData(ssramWrData), .ssramDataEn(ssramDataEn),
      .ssramRdData(ssramRdData)
   );

   always #5 clk = !clk;

   // Hang guard
   always @(posedge clk)
   begin
      cycleCount++;
      if (cycleCount > cycleLimit)
      begin
         $display("Timeout, the run did not finish within %0d cycles", cycleLimit);
         $display("** FAIL **");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Random numbers and request words
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] nextRand();
      rngState = rngState * 32'd1664525 + 32'd1013904223;
      return rngState;
   endfunction

   // Upper bits only since the low LCG bits are weak
   function automatic int pick(input int n);
      logic [31:0] r;
      r = nextRand();
      return int'(r[31:8]) % n;
   endfunction

   // Upper bits of two draws make one word
   function automatic ks10MemPkg::word36_t rand36();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = nextRand();
      lo = nextRand();
      return {hi[31:16], lo[31:12]};
   endfunction

   // Power-up contents of the SSRAM
   function automatic logic [35:0] initialWord(input logic [19:0] a);
      return (36'(a) * 36'd40503) ^ 36'hA5A5A5A5A;
   endfunction

   function automatic ks10MemPkg::word36_t memRequest(input logic rd, input logic wrTest,
         input logic wr, input logic acRef, input logic [7:0] idx);
      ks10MemPkg::word36_t a;
      a = 36'(windowBase + 20'(idx));
      a[ks10MemPkg::flagRead]   = rd;
      a[ks10MemPkg::flagWrTest] = wrTest;
      a[ks10MemPkg::flagWrite]  = wr;
      a[ks10MemPkg::flagAcRef]  = acRef;
      a[ks10MemPkg::flagPhys]   = 1'b1;
      return a;
   endfunction

   function automatic ks10MemPkg::word36_t ioRequest(input logic rd, input logic wr,
         input ks10MemPkg::devNum_t dev, input ks10MemPkg::ioAddr_t ioAddr);
      ks10MemPkg::word36_t a;
      a = '0;
      a[ks10MemPkg::flagIo]    = 1'b1;
      a[ks10MemPkg::flagRead]  = rd;
      a[ks10MemPkg::flagWrite] = wr;
      a[ks10MemPkg::devLsb-3 +: 4]  = dev;
      a[ks10MemPkg::devLsb+1 +: 18] = ioAddr;
      return a;
   endfunction

   ////////////////////////////////////////////////////////////
   // Checks and the handshake
   ////////////////////////////////////////////////////////////

   task automatic expectEq(input string sig, input logic [35:0] exp, input logic [35:0] got);
      testChecks++;
      assert (got === exp)
      else
      begin
         $display("FAIL time %0t %s expected %0h got %0h", $time, sig, exp, got);
         testFails++;
      end
   endtask

   task automatic finishTest(input string name);
      $display("Test %s: %0d checks, %0d failed", name, testChecks, testFails);
      totalChecks += testChecks;
      totalFails += testFails;
      testChecks = 0;
      testFails = 0;
   endtask

   // One four-phase handshake
   // A negative expLat expects no answer
   task automatic busCycle(input ks10MemPkg::word36_t addr, input ks10MemPkg::word36_t data,
         input int expLat, input int holdMin, input int holdMax,
         output ks10MemPkg::word36_t rdData);
      int   waited;
      int   hold;
      logic acked;
      busAddr = addr;
      busWrData = data;
      busReq = 1'b1;
      waited = 0;
      acked = 1'b0;
      rdData = '0;
      while (!acked && waited < ackLimit)
      begin
         @(negedge clk);
         waited++;
         acked = busAck;
      end
      testChecks++;
      if (expLat < 0)
      begin
         assert (!acked)
         else
         begin
            $display("Request %h for another device was acknowledged at %0t", addr, $time);
            testFails++;
         end
      end
      else
      begin
         assert (acked)
         else
         begin
            $display("Request %h got no busAck within %0d cycles", addr, ackLimit);
            testFails++;
         end
      end
      if (acked && expLat >= 0)
      begin
         // Seen one falling edge after the rising edge that set it
         expectEq("busAck latency", 36'(expLat), 36'(waited - 1));
         rdData = busRdData;
         hold = holdMin + pick(holdMax - holdMin + 1);
         repeat (hold)
         begin
            @(negedge clk);
            expectEq("busAck", 36'd1, 36'(busAck));
            expectEq("busRdData", rdData, busRdData);
         end
      end
      busReq = 1'b0;
      @(negedge clk);
      expectEq("busAck", 36'd0, 36'(busAck));
   endtask

   ////////////////////////////////////////////////////////////
   // Transaction kinds
   ////////////////////////////////////////////////////////////

   task automatic memAccess(input int holdMin, input int holdMax);
      int                  kind;
      logic [7:0]          idx;
      ks10MemPkg::word36_t data;
      ks10MemPkg::word36_t got;
      kind = pick(4);
      idx = 8'(pick(256));
      data = rand36();
      if (kind < 2)
      begin
         busCycle(memRequest(1'b0, 1'b0, 1'b1, 1'b0, idx), data, 3, holdMin, holdMax, got);
         modelMem[idx] = data;
      end
      else
      begin
         // Write-test returns data like a read
         busCycle(memRequest(kind == 2, kind == 3, 1'b0, 1'b0, idx), data, 4,
                  holdMin, holdMax, got);
         expectEq("busRdData", modelMem[idx], got);
      end
   endtask

   task automatic msrAccess(input logic write, input int holdMin, input int holdMax);
      ks10MemPkg::word36_t data;
      ks10MemPkg::word36_t got;
      ks10MemPkg::word36_t exp;
      data = rand36();
      if (write)
      begin
         busCycle(ioRequest(1'b0, 1'b1, ks10MemPkg::memDev, ks10MemPkg::addrMsr), data, 1,
                  holdMin, holdMax, got);
         modelPe = data[ks10MemPkg::msrPe];
         // PF can only be cleared
         modelPf = modelPf & data[ks10MemPkg::msrPf];
         modelEe = !data[ks10MemPkg::msrEd];
      end
      else
      begin
         busCycle(ioRequest(1'b1, 1'b0, ks10MemPkg::memDev, ks10MemPkg::addrMsr), data, 1,
                  holdMin, holdMax, got);
         // Reserved bits read as 0
         exp = '0;
         exp[ks10MemPkg::msrPe] = modelPe;
         exp[ks10MemPkg::msrEe] = modelEe;
         exp[ks10MemPkg::msrPf] = modelPf;
         expectEq("busRdData", exp, got);
      end
   endtask

   // AC write then a read that must see the old word
   task automatic acRefWrite(input int holdMin, input int holdMax);
      logic [7:0]          idx;
      ks10MemPkg::word36_t got;
      idx = 8'(pick(256));
      busCycle(memRequest(1'b0, 1'b0, 1'b1, 1'b1, idx), rand36(), 1, holdMin, holdMax, got);
      busCycle(memRequest(1'b1, 1'b0, 1'b0, 1'b0, idx), rand36(), 4, holdMin, holdMax, got);
      expectEq("busRdData", modelMem[idx], got);
   endtask

   // Other device, or device 0 at another register
   task automatic unaddressedIo(input int holdMin, input int holdMax);
      ks10MemPkg::devNum_t dev;
      ks10MemPkg::ioAddr_t ioAddr;
      ks10MemPkg::word36_t got;
      logic                wr;
      dev = ks10MemPkg::memDev;
      ioAddr = ks10MemPkg::addrMsr;
      if (pick(2) == 0)
      begin
         dev = 4'(1 + pick(15));
      end
      else
      begin
         ioAddr = ks10MemPkg::addrMsr ^ 18'(1 + pick(4096));
      end
      wr = pick(2) == 1;
      busCycle(ioRequest(!wr, wr, dev, ioAddr), rand36(), -1, holdMin, holdMax, got);
   endtask

   task automatic mixedTraffic(input int holdMin, input int holdMax);
      int kind;
      kind = pick(4);
      case (kind)
         0: memAccess(holdMin, holdMax);
         1: msrAccess(pick(2) == 1, holdMin, holdMax);
         2: acRefWrite(holdMin, holdMax);
         default: unaddressedIo(holdMin, holdMax);
      endcase
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      clk = 1'b0;
      rst = 1'b1;
      busReq = 1'b0;
      busAddr = '0;
      busWrData = '0;
      // Model at power-up
      modelPe = 1'b0;
      modelEe = 1'b1;
      modelPf = 1'b1;
      for (int i = 0; i < 256; i++)
      begin
         modelMem[i] = initialWord(windowBase + 20'(i));
      end
      repeat (2) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      expectEq("busAck", 36'd0, 36'(busAck));
      expectEq("ssramCe", 36'd0, 36'(ssramCe));
      expectEq("ssramOeN", 36'd1, 36'(ssramOeN));
      expectEq("ssramWeN", 36'd1, 36'(ssramWeN));
      expectEq("ssramDataEn", 36'd0, 36'(ssramDataEn));
      msrAccess(1'b0, 0, 2);
      finishTest("reset state");

      repeat (nMem) memAccess(0, 2);
      finishTest("memory traffic");
      repeat (nMsr) msrAccess(pick(3) != 0, 0, 2);
      finishTest("status register");
      repeat (nAc) acRefWrite(0, 2);
      finishTest("AC-reference write");
      repeat (nUna) unaddressedIo(0, 2);
      finishTest("unaddressed request");
      // Longer holds after busAck
      repeat (nMix) mixedTraffic(1, 4);
      finishTest("back-pressure");

      $display("Totals: %0d checks passed, %0d failed", totalChecks - totalFails, totalFails);
      if (totalFails == 0)
      begin
         $display("** PASS **");
      end
      else
      begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== tests/ssramModel.sv ====
/*
 * Behavioral synchronous SRAM for simulation only.
 * Read data is registered and valid one clock after CE with OE# low.
 * A write needs CE, WE# low and the data enable in the same cycle.
 * Every word starts out with a pattern made from its address.
 */

module ssramModel
#(
   parameter int addrWidth = 20
)
(
   input  logic                 clk,
   input  logic [addrWidth-1:0] ssramAddr,
   input  logic                 ssramCe,
   input  logic                 ssramOeN,
   input  logic                 ssramWeN,
   input  ks10MemPkg::word36_t  ssramWrData,
   input  logic                 ssramDataEn,
   output ks10MemPkg::word36_t  ssramRdData
);

   timeunit 1ns;
   timeprecision 100ps;

   logic [35:0] mem [0:(1 << addrWidth) - 1];

   // Odd multiplier keeps every word distinct
   initial
   begin
      for (int i = 0; i < (1 << addrWidth); i++)
      begin
         mem[i] = (36'(i) * 36'd40503) ^ 36'hA5A5A5A5A;
      end
   end

   always @(posedge clk)
   begin
      if (ssramCe && !ssramWeN && ssramDataEn)
      begin
         mem[ssramAddr] = ssramWrData;
      end
      // One cycle of read latency
      if (ssramCe && !ssramOeN)
      begin
         ssramRdData <= mem[ssramAddr];
      end
   end

endmodule

// ==== src/ks10Mem.sv ====
/*
 * Top level of the KS-10 memory interface.
 * SSRAM data is split into read, write and output-enable signals.
 * addrWidth sets the SSRAM address width taken from the bus address.
 */

module ks10Mem
#(
   parameter int addrWidth = 20
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 busReq,
   output logic                 busAck,
   input  ks10MemPkg::word36_t  busAddr,
   input  ks10MemPkg::word36_t  busWrData,
   output ks10MemPkg::word36_t  busRdData,
   output logic [addrWidth-1:0] ssramAddr,
   output logic                 ssramCe,
   output logic                 ssramOeN,
   output logic                 ssramWeN,
   output ks10MemPkg::word36_t  ssramWrData,
   output logic                 ssramDataEn,
   input  ks10MemPkg::word36_t  ssramRdData
);

   // Status register path
   logic                 msrWrite;
   ks10MemPkg::word36_t  msrWord;

   // Sequencer path
   logic                 seqStart;
   logic                 seqWrite;
   logic [addrWidth-1:0] seqAddr;
   logic                 seqDone;
   ks10MemPkg::word36_t  seqRdData;

   ////////////////////////////////////////////////////////////
   // Bus slave, status register and SSRAM sequencer
   ////////////////////////////////////////////////////////////

   memBusSlave #(.addrWidth(addrWidth)) slave
   (
      .clk(clk), .rst(rst), .busReq(busReq), .busAck(busAck), .busAddr(busAddr),
      .busRdData(busRdData), .msrWrite(msrWrite), .msrWord(msrWord),
      .seqStart(seqStart), .seqWrite(seqWrite), .seqAddr(seqAddr),
      .seqDone(seqDone), .seqRdData(seqRdData)
   );

   memStatus status
   (
      .clk(clk), .rst(rst), .msrWrite(msrWrite), .busWrData(busWrData), .msrWord(msrWord)
   );

   ssramSeq #(.addrWidth(addrWidth)) seq
   (
      .clk(clk), .rst(rst), .seqStart(seqStart), .seqWrite(seqWrite), .seqAddr(seqAddr),
      .busWrData(busWrData), .seqDone(seqDone), .seqRdData(seqRdData),
      .ssramAddr(ssramAddr), .ssramCe(ssramCe), .ssramOeN(ssramOeN),
      .ssramWeN(ssramWeN), .ssramWrData(ssramWrData), .ssramDataEn(ssramDataEn),
      .ssramRdData(ssramRdData)
   );

endmodule

// ==== src/memBusSlave.sv ====
/*
 * Backplane side of the memory interface.
 * Uses a four-phase req/ack handshake with one transaction at a time.
 * The master must hold the address and data while busReq is high.
 * I/O requests for other devices are left unanswered.
 */

module memBusSlave
#(
   parameter int addrWidth = 20
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 busReq,
   output logic                 busAck,
   input  ks10MemPkg::word36_t  busAddr,
   output ks10MemPkg::word36_t  busRdData,
   output logic                 msrWrite,
   input  ks10MemPkg::word36_t  msrWord,
   output logic                 seqStart,
   output logic                 seqWrite,
   output logic [addrWidth-1:0] seqAddr,
   input  logic                 seqDone,
   input  ks10MemPkg::word36_t  seqRdData
);

   ////////////////////////////////////////////////////////////
   // Address word fields
   ////////////////////////////////////////////////////////////

   logic                busRead;
   logic                busWrTest;
   logic                busWrite;
   logic                busIo;
   logic                busAcRef;
   ks10MemPkg::devNum_t busDev;
   ks10MemPkg::ioAddr_t busIoAddr;

   assign busRead   = busAddr[ks10MemPkg::flagRead];
   assign busWrTest = busAddr[ks10MemPkg::flagWrTest];
   assign busWrite  = busAddr[ks10MemPkg::flagWrite];
   assign busIo     = busAddr[ks10MemPkg::flagIo];
   assign busAcRef  = busAddr[ks10MemPkg::flagAcRef];
   assign busDev    = busAddr[ks10MemPkg::devLsb-3 +: 4];
   assign busIoAddr = busAddr[ks10MemPkg::devLsb+1 +: 18];

   // Request classes
   logic msrHit;
   logic memHit;
   logic acRefWr;
   logic memCycle;

   assign msrHit = busIo && busDev == ks10MemPkg::memDev &&
                   busIoAddr == ks10MemPkg::addrMsr && (busRead || busWrite);
   assign memHit = !busIo && (busRead || busWrTest || busWrite);

   // AC writes are acked but never reach the SSRAM
   assign acRefWr  = memHit && busWrite && busAcRef && !busRead && !busWrTest;
   assign memCycle = memHit && !acRefWr;

   // Read and write-test both read the SSRAM
   assign seqWrite = busWrite && !busRead && !busWrTest;
   assign seqAddr  = busAddr[36-addrWidth +: addrWidth];

   ////////////////////////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////////////////////////

   ks10MemPkg::slvState_t state;
   // Waiting on the sequencer rather than a local register
   logic                  memPending;
   logic                  waitDone;

   assign waitDone = state == ks10MemPkg::slvStWait && (!memPending || seqDone);
   assign busAck   = state == ks10MemPkg::slvStAck;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state      <= ks10MemPkg::slvStIdle;
         memPending <= 1'b0;
         seqStart   <= 1'b0;
         msrWrite   <= 1'b0;
      end
      else
      begin
         // Single-cycle strobes
         seqStart <= 1'b0;
         msrWrite <= 1'b0;
         case (state)
            ks10MemPkg::slvStIdle:
            begin
               if (busReq && (msrHit || memHit))
               begin
                  state      <= ks10MemPkg::slvStWait;
                  memPending <= memCycle;
                  seqStart   <= memCycle;
                  msrWrite   <= msrHit && busWrite;
               end
            end
            ks10MemPkg::slvStWait:
            begin
               if (waitDone)
               begin
                  state <= ks10MemPkg::slvStAck;
               end
            end
            // Hold ack until the master lets go
            default:
            begin
               if (!busReq)
               begin
                  state <= ks10MemPkg::slvStIdle;
               end
            end
         endcase
      end
   end

   // Read data frozen from ack until the next request
   always_ff @(posedge clk)
   begin
      if (waitDone)
      begin
         busRdData <= memPending ? seqRdData : msrWord;
      end
   end

   // Ack only answers a request seen on the previous edge
   assert property (@(posedge clk) disable iff (rst) $rose(busAck) |-> $past(busReq));

endmodule

// ==== src/ssramSeq.sv ====
/*
 * Runs a single SSRAM read or write per start pulse.
 * The SSRAM is assumed to return read data one clock after OE# is sampled.
 * No burst and no byte writes. Start is ignored unless idle.
 */

module ssramSeq
#(
   parameter int addrWidth = 20
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 seqStart,
   input  logic                 seqWrite,
   input  logic [addrWidth-1:0] seqAddr,
   input  ks10MemPkg::word36_t  busWrData,
   output logic                 seqDone,
   output ks10MemPkg::word36_t  seqRdData,
   output logic [addrWidth-1:0] ssramAddr,
   output logic                 ssramCe,
   output logic                 ssramOeN,
   output logic                 ssramWeN,
   output ks10MemPkg::word36_t  ssramWrData,
   output logic                 ssramDataEn,
   input  ks10MemPkg::word36_t  ssramRdData
);

   ks10MemPkg::seqState_t state;

   // Request held for the whole cycle
   logic [addrWidth-1:0] addrReg;
   logic                 wrReg;
   ks10MemPkg::word36_t  wrDataReg;
   ks10MemPkg::word36_t  rdDataReg;

   ////////////////////////////////////////////////////////////
   // Sequencer
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= ks10MemPkg::seqStIdle;
      end
      else
      begin
         case (state)
            ks10MemPkg::seqStIdle:
            begin
               if (seqStart)
               begin
                  state <= ks10MemPkg::seqStAddr;
               end
            end
            // Writes finish here, reads wait for the data
            ks10MemPkg::seqStAddr:
            begin
               state <= wrReg ? ks10MemPkg::seqStDone : ks10MemPkg::seqStData;
            end
            ks10MemPkg::seqStData:
            begin
               state <= ks10MemPkg::seqStDone;
            end
            default:
            begin
               state <= ks10MemPkg::seqStIdle;
            end
         endcase
      end
   end

   // Latch the request on start, capture read data in Data
   always_ff @(posedge clk)
   begin
      if (state == ks10MemPkg::seqStIdle && seqStart)
      begin
         addrReg   <= seqAddr;
         wrReg     <= seqWrite;
         wrDataReg <= busWrData;
      end
      if (state == ks10MemPkg::seqStData)
      begin
         rdDataReg <= ssramRdData;
      end
   end

   ////////////////////////////////////////////////////////////
   // SSRAM pins
   ////////////////////////////////////////////////////////////

   assign ssramAddr   = addrReg;
   assign ssramWrData = wrDataReg;
   assign ssramCe     = state == ks10MemPkg::seqStAddr;
   assign ssramOeN    = !(state == ks10MemPkg::seqStAddr && !wrReg);
   assign ssramWeN    = !(state == ks10MemPkg::seqStAddr && wrReg);
   assign ssramDataEn = state == ks10MemPkg::seqStAddr && wrReg;
   assign seqDone     = state == ks10MemPkg::seqStDone;
   assign seqRdData   = rdDataReg;

   // Read and write strobes are exclusive
   assert property (@(posedge clk) disable iff (rst) ssramOeN || ssramWeN);

   // Every start completes in 2 cycles for a write, 3 for a read
   assert property (@(posedge clk) disable iff (rst) seqStart |-> ##[2:3] seqDone);

endmodule

// ==== src/memStatus.sv ====
/*
 * Memory Status Register at I/O address 100000 octal.
 * Only PE, EE and PF are kept. Every other bit reads as 0.
 * PF comes up set after reset and can only be cleared by a write.
 */

module memStatus
(
   input  logic                clk,
   input  logic                rst,
   input  logic                msrWrite,
   input  ks10MemPkg::word36_t busWrData,
   output ks10MemPkg::word36_t msrWord
);

   // Parity Error
   logic statPe;
   // ECC Enable
   logic statEe;
   // Power Failure
   logic statPf;

   ////////////////////////////////////////////////////////////
   // Register write
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         // Power-up values
         statPe <= 1'b0;
         statEe <= 1'b1;
         statPf <= 1'b1;
      end
      else if (msrWrite)
      begin
         // PE is plain read/write
         statPe <= busWrData[ks10MemPkg::msrPe];
         // Writing 0 clears PF, writing 1 keeps it
         statPf <= busWrData[ks10MemPkg::msrPf] & statPf;
         // EE is the inverse of ED
         statEe <= !busWrData[ks10MemPkg::msrEd];
      end
   end

   ////////////////////////////////////////////////////////////
   // Read-back word
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      // Reserved fields
      msrWord = '0;
      msrWord[ks10MemPkg::msrPe] = statPe;
      msrWord[ks10MemPkg::msrEe] = statEe;
      msrWord[ks10MemPkg::msrPf] = statPf;
   end

endmodule

// ==== src/ks10MemPkg.sv ====
/*
 * Shared types and constants for the KS-10 memory interface.
 * Bus words use backplane numbering with bit 0 as the MSB.
 * Flag positions follow the KS-10 address word layout. AC-reference is one flag bit.
 */

package ks10MemPkg;

   ////////////////////////////////////////////////////////////
   // Word types
   ////////////////////////////////////////////////////////////

   // Data or address word as seen on the backplane
   typedef logic [0:35] word36_t;

   // I/O device number, bits 14 to 17 of the address word
   typedef logic [0:3] devNum_t;

   // I/O register address, right half of the address word
   typedef logic [18:35] ioAddr_t;

   ////////////////////////////////////////////////////////////
   // Address word flags
   ////////////////////////////////////////////////////////////

   parameter int flagRead   = 3;
   parameter int flagWrTest = 4;
   parameter int flagWrite  = 5;
   parameter int flagPhys   = 8;
   parameter int flagIo     = 10;
   parameter int flagAcRef  = 12;

   // Last bit of the device field, which is 4 bits wide
   parameter int devLsb = 17;

   // This controller answers as device 0
   parameter devNum_t memDev  = 4'd0;
   parameter ioAddr_t addrMsr = 18'o100000;

   ////////////////////////////////////////////////////////////
   // Memory Status Register bits
   ////////////////////////////////////////////////////////////

   parameter int msrPe = 3;
   parameter int msrEe = 4;
   parameter int msrPf = 12;
   // ECC Disable, write only
   parameter int msrEd = 35;

   // SSRAM sequencer states
   typedef enum logic [1:0] {seqStIdle, seqStAddr, seqStData, seqStDone} seqState_t;

   // Bus slave handshake states
   typedef enum logic [1:0] {slvStIdle, slvStWait, slvStAck} slvState_t;

endpackage
